//--- logic/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////

// Width of one data word and one instruction
`define RV_XLEN 32

// Architectural register count, x0 included
`define RV_NREGS 32

// Bits needed to index one register
`define RV_RADDR_W 5

`endif

//--- logic/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    ////////////////////////////////////////////////
    // Width types
    ////////////////////////////////////////////////

    typedef logic [`RV_XLEN-1:0]    word_t;
    typedef logic [`RV_RADDR_W-1:0] reg_addr_t;
    typedef logic [`RV_XLEN-1:0]    instr_t;

    ////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////

    // ALU function, handed straight to execute
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    // Branch condition; BR_JUMP is unconditional
    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
    } branch_t;

    // Immediate layout picked by the decoder
    typedef enum logic [2:0] {
        IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_t;

    ////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////

    // 26-bit control word, rd in the top bits
    typedef struct packed {
        reg_addr_t rd;
        reg_addr_t rs2;
        reg_addr_t rs1;
        alu_op_t   alu_fn;
        logic      reg_we;
        logic      mem_read;
        logic      mem_to_reg;
        logic      b_is_imm;
        logic [2:0] mem_type;
    } ctrl_t;

    // Writeback port back into the register file
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_port_t;

    // Everything that crosses from ID into EX
    typedef struct packed {
        ctrl_t   ctrl;
        branch_t branch;
        word_t   op_a;
        word_t   op_b;
        word_t   store_data;
        word_t   pc_plus4;
        logic    pred_taken;
    } id_ex_t;

endpackage

//--- logic/rv32i_decoder.sv
`timescale 1ns/100ps

module rv32i_decoder (
    input  rv_pkg::instr_t   instr_i,
    output rv_pkg::ctrl_t    ctrl_o,
    output rv_pkg::branch_t  branch_o,
    output rv_pkg::imm_fmt_t imm_fmt_o
);

    // Base opcodes, bits 6:0 including the 11 suffix
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // Instruction fields
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    rv_pkg::reg_addr_t rd_f;
    rv_pkg::reg_addr_t rs1_f;
    rv_pkg::reg_addr_t rs2_f;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rd_f      = instr_i[11:7];
    assign rs1_f     = instr_i[19:15];
    assign rs2_f     = instr_i[24:20];

    // funct3 to ALU function; alt picks SUB or SRA
    function automatic rv_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        rv_pkg::alu_op_t fn;
        case (f3)
            3'b000:  fn = alt ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b001:  fn = rv_pkg::ALU_SLL;
            3'b010:  fn = rv_pkg::ALU_SLT;
            3'b011:  fn = rv_pkg::ALU_SLTU;
            3'b100:  fn = rv_pkg::ALU_XOR;
            3'b101:  fn = alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
            3'b110:  fn = rv_pkg::ALU_OR;
            default: fn = rv_pkg::ALU_AND;
        endcase
        return fn;
    endfunction

    // Branch funct3 to condition
    function automatic rv_pkg::branch_t br_from_funct3(input logic [2:0] f3);
        rv_pkg::branch_t br;
        case (f3)
            3'b000:  br = rv_pkg::BR_EQ;
            3'b001:  br = rv_pkg::BR_NE;
            3'b100:  br = rv_pkg::BR_LT;
            3'b101:  br = rv_pkg::BR_GE;
            3'b110:  br = rv_pkg::BR_LTU;
            3'b111:  br = rv_pkg::BR_GEU;
            default: br = rv_pkg::BR_NONE;
        endcase
        return br;
    endfunction

    ////////////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////////////

    always_comb begin
        // Unknown opcode leaves everything at zero
        ctrl_o    = '0;
        branch_o  = rv_pkg::BR_NONE;
        imm_fmt_o = rv_pkg::IMM_I;
        case (opcode)
            OPC_LUI: begin
                ctrl_o.rd       = rd_f;
                ctrl_o.alu_fn   = rv_pkg::ALU_PASS_B;
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                imm_fmt_o       = rv_pkg::IMM_U;
            end
            OPC_AUIPC: begin
                // rs1 stays 0, execute adds the PC elsewhere
                ctrl_o.rd       = rd_f;
                ctrl_o.alu_fn   = rv_pkg::ALU_ADD;
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                imm_fmt_o       = rv_pkg::IMM_U;
            end
            OPC_JAL: begin
                ctrl_o.rd       = rd_f;
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                branch_o        = rv_pkg::BR_JUMP;
                imm_fmt_o       = rv_pkg::IMM_J;
            end
            OPC_JALR: begin
                ctrl_o.rd       = rd_f;
                ctrl_o.rs1      = rs1_f;
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
                branch_o        = rv_pkg::BR_JUMP;
            end
            OPC_BRANCH: begin
                // Compare rides on rs2 via store_data, offset on op B
                ctrl_o.rs1      = rs1_f;
                ctrl_o.rs2      = rs2_f;
                ctrl_o.alu_fn   = rv_pkg::ALU_SUB;
                ctrl_o.b_is_imm = 1'b1;
                branch_o        = br_from_funct3(funct3);
                imm_fmt_o       = rv_pkg::IMM_B;
            end
            OPC_LOAD: begin
                ctrl_o.rd         = rd_f;
                ctrl_o.rs1        = rs1_f;
                ctrl_o.reg_we     = 1'b1;
                ctrl_o.mem_read   = 1'b1;
                ctrl_o.mem_to_reg = 1'b1;
                ctrl_o.b_is_imm   = 1'b1;
                ctrl_o.mem_type   = funct3;
            end
            OPC_STORE: begin
                ctrl_o.rs1      = rs1_f;
                ctrl_o.rs2      = rs2_f;
                ctrl_o.b_is_imm = 1'b1;
                ctrl_o.mem_type = funct3;
                imm_fmt_o       = rv_pkg::IMM_S;
            end
            OPC_OPIMM: begin
                // Only the shift-right slot honours bit 30 here
                ctrl_o.rd       = rd_f;
                ctrl_o.rs1      = rs1_f;
                ctrl_o.alu_fn   = alu_from_funct3(funct3, funct7_b5 && (funct3 == 3'b101));
                ctrl_o.reg_we   = 1'b1;
                ctrl_o.b_is_imm = 1'b1;
            end
            OPC_OP: begin
                ctrl_o.rd     = rd_f;
                ctrl_o.rs1    = rs1_f;
                ctrl_o.rs2    = rs2_f;
                ctrl_o.alu_fn = alu_from_funct3(funct3, funct7_b5);
                ctrl_o.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/100ps

`include "rv_defs.svh"

module imm_gen (
    input  rv_pkg::instr_t   instr_i,
    input  rv_pkg::imm_fmt_t fmt_i,
    output rv_pkg::word_t    imm_o
);

    // Sign bit is always instruction bit 31
    logic sgn;

    assign sgn = instr_i[31];

    ////////////////////////////////////////////////
    // Format assembly
    ////////////////////////////////////////////////

    always_comb begin
        case (fmt_i)
            rv_pkg::IMM_I: imm_o = {{(`RV_XLEN-12){sgn}}, instr_i[31:20]};
            rv_pkg::IMM_S: imm_o = {{(`RV_XLEN-12){sgn}}, instr_i[31:25], instr_i[11:7]};
            // B and J scale by two, bit 0 always clear
            rv_pkg::IMM_B: imm_o = {{(`RV_XLEN-13){sgn}}, sgn, instr_i[7],
                                    instr_i[30:25], instr_i[11:8], 1'b0};
            rv_pkg::IMM_J: imm_o = {{(`RV_XLEN-21){sgn}}, sgn, instr_i[19:12],
                                    instr_i[20], instr_i[30:21], 1'b0};
            // Upper immediate, low 12 bits zero
            rv_pkg::IMM_U: imm_o = {instr_i[31:12], 12'b0};
            default:       imm_o = '0;
        endcase
    end

endmodule

//--- logic/register_file.sv
`timescale 1ns/100ps

`include "rv_defs.svh"

module register_file (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::wb_port_t  wb_i,
    output rv_pkg::word_t     rs1_data_o,
    output rv_pkg::word_t     rs2_data_o
);

    // Storage, entry 0 never written
    rv_pkg::word_t regs [`RV_NREGS];

    // x0 reads zero; same-cycle writeback wins over the array
    function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr,
                                                input rv_pkg::word_t stored,
                                                input rv_pkg::wb_port_t wb);
        rv_pkg::word_t val;
        if (addr == '0)
            val = '0;
        else if (wb.we && (wb.rd == addr))
            val = wb.data;
        else
            val = stored;
        return val;
    endfunction

    ////////////////////////////////////////////////
    // Write port
    ////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end else if (wb_i.we && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // Two identical read ports
    assign rs1_data_o = read_port(rs1_i, regs[rs1_i], wb_i);
    assign rs2_data_o = read_port(rs2_i, regs[rs2_i], wb_i);

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  rv_pkg::instr_t    instr_i,
    input  rv_pkg::word_t     pc_plus4_i,
    input  logic              pred_taken_i,
    input  logic              bubble_i,
    input  rv_pkg::wb_port_t  wb_i,
    output rv_pkg::id_ex_t    id_o
);

    // Raw decoder outputs, before masking
    rv_pkg::ctrl_t    dec_ctrl;
    rv_pkg::branch_t  dec_branch;
    rv_pkg::imm_fmt_t imm_fmt;
    rv_pkg::word_t    imm;
    rv_pkg::word_t    rs1_data;
    rv_pkg::word_t    rs2_data;
    logic             ctrl_keep;

    ////////////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////////////

    rv32i_decoder u_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (dec_ctrl),
        .branch_o  (dec_branch),
        .imm_fmt_o (imm_fmt)
    );

    imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    // Read addresses come from ctrl so AUIPC and LUI read x0
    register_file u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_i      (dec_ctrl.rs1),
        .rs2_i      (dec_ctrl.rs2),
        .wb_i       (wb_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // Kill control on a bubble or a non-32-bit encoding
    assign ctrl_keep = !bubble_i && (instr_i[1:0] == 2'b11);

    ////////////////////////////////////////////////
    // ID/EX word assembly
    ////////////////////////////////////////////////

    always_comb begin
        id_o.ctrl       = ctrl_keep ? dec_ctrl : '0;
        id_o.branch     = ctrl_keep ? dec_branch : rv_pkg::BR_NONE;
        id_o.op_a       = rs1_data;
        // Operand B mux
        id_o.op_b       = dec_ctrl.b_is_imm ? imm : rs2_data;
        id_o.store_data = rs2_data;
        id_o.pc_plus4   = pc_plus4_i;
        id_o.pred_taken = pred_taken_i;
    end

endmodule

//--- logic/id_ex_register.sv
`timescale 1ns/100ps

module id_ex_register (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  rv_pkg::id_ex_t id_i,
    output rv_pkg::id_ex_t id_ex_o
);

    // Control half, cleared by reset
    rv_pkg::ctrl_t   ctrl_q;
    rv_pkg::branch_t branch_q;

    // Payload half, free running
    rv_pkg::word_t op_a_q;
    rv_pkg::word_t op_b_q;
    rv_pkg::word_t store_data_q;
    rv_pkg::word_t pc_plus4_q;
    logic          pred_taken_q;

    ////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ctrl_q   <= '0;
            branch_q <= rv_pkg::BR_NONE;
        end else begin
            ctrl_q   <= id_i.ctrl;
            branch_q <= id_i.branch;
        end
    end

    always_ff @(posedge clk_i) begin
        op_a_q       <= id_i.op_a;
        op_b_q       <= id_i.op_b;
        store_data_q <= id_i.store_data;
        pc_plus4_q   <= id_i.pc_plus4;
        pred_taken_q <= id_i.pred_taken;
    end

    // Repack for EX
    assign id_ex_o = '{ctrl: ctrl_q, branch: branch_q, op_a: op_a_q, op_b: op_b_q,
                       store_data: store_data_q, pc_plus4: pc_plus4_q,
                       pred_taken: pred_taken_q};

endmodule

//--- logic/id_top.sv
`timescale 1ns/100ps

module id_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  rv_pkg::instr_t   instr_i,
    input  rv_pkg::word_t    pc_plus4_i,
    input  logic             pred_taken_i,
    input  logic             bubble_i,
    input  rv_pkg::wb_port_t wb_i,
    output rv_pkg::id_ex_t   id_ex_o
);

    // Combinational ID result, same cycle as instr_i
    rv_pkg::id_ex_t id_d;

    ////////////////////////////////////////////////
    // Decode then register
    ////////////////////////////////////////////////

    decode_stage u_decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .pc_plus4_i   (pc_plus4_i),
        .pred_taken_i (pred_taken_i),
        .bubble_i     (bubble_i),
        .wb_i         (wb_i),
        .id_o         (id_d)
    );

    id_ex_register u_id_ex (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .id_i    (id_d),
        .id_ex_o (id_ex_o)
    );

endmodule

//--- verif/id_top_tb.sv
`timescale 1ns/100ps

module id_top_tb;

    localparam int CLK_PERIOD  = 40;
    // Cycles for reset and then each test in sequence order
    localparam int TEST_CYCLES = 3 + 31 + 6 + 3 + 12 + 2 + 8;
    localparam int MARGIN      = 20;
    localparam rv_pkg::wb_port_t NO_WB = '0;

    logic              clk_i = 1'b0;
    logic              rst_n_i;
    rv_pkg::instr_t    instr_i;
    rv_pkg::word_t     pc_plus4_i;
    logic              pred_taken_i;
    logic              bubble_i;
    rv_pkg::wb_port_t  wb_i;
    rv_pkg::id_ex_t    id_ex_o;

    // Bookkeeping
    int            errors = 0;
    int            checks = 0;
    logic [31:0]   lcg_state = 32'h7d7a_e67f;
    rv_pkg::word_t shadow [32];

    id_top UUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .pc_plus4_i   (pc_plus4_i),
        .pred_taken_i (pred_taken_i),
        .bubble_i     (bubble_i),
        .wb_i         (wb_i),
        .id_ex_o      (id_ex_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Numerical Recipes constants
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Random register index that is never x0
    function automatic rv_pkg::reg_addr_t rand_reg();
        logic [31:0] r;
        r = next_rand();
        return (r[20:16] == 5'd0) ? 5'd1 : r[20:16];
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Drive on the falling edge and sample just after the capturing rising edge
    task automatic issue(input rv_pkg::instr_t instr, input rv_pkg::word_t pc4,
                         input logic pred, input logic bub, input rv_pkg::wb_port_t wb);
        @(negedge clk_i);
        instr_i      = instr;
        pc_plus4_i   = pc4;
        pred_taken_i = pred;
        bubble_i     = bub;
        wb_i         = wb;
        @(posedge clk_i);
        #1;
    endtask

    // R-type ADD or SUB encoding
    function automatic rv_pkg::instr_t enc_addsub(input logic sub, input rv_pkg::reg_addr_t rs2,
                                                  input rv_pkg::reg_addr_t rs1,
                                                  input rv_pkg::reg_addr_t rd);
        return {sub ? 7'h20 : 7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        // A live JAL to x1 sits on the input while reset holds the control half
        instr_i = {20'h00000, 5'd1, 7'b1101111};
        repeat (2) @(posedge clk_i);
        #1;
        check_val("reset ctrl", 32'd0, 32'(id_ex_o.ctrl));
        check_val("reset branch", 32'(rv_pkg::BR_NONE), 32'(id_ex_o.branch));
        @(negedge clk_i);
        rst_n_i = 1'b1;
        instr_i = '0;
    endtask

    task automatic test_reg_rw();
        rv_pkg::wb_port_t  wb;
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::reg_addr_t rd;
        logic              sub;
        // Fill x1..x31 with random data
        for (int i = 1; i < 32; i++) begin
            wb.we   = 1'b1;
            wb.rd   = i[4:0];
            wb.data = next_rand();
            issue(32'h0, 32'h0, 1'b0, 1'b0, wb);
            shadow[i] = wb.data;
        end
        for (int k = 0; k < 6; k++) begin
            rs1 = rand_reg();
            rs2 = rand_reg();
            rd  = rand_reg();
            sub = k[0];
            issue(enc_addsub(sub, rs2, rs1, rd), 32'h0, 1'b0, 1'b0, NO_WB);
            check_val("addsub op_a", shadow[rs1], id_ex_o.op_a);
            check_val("addsub op_b", shadow[rs2], id_ex_o.op_b);
            check_val("addsub store_data", shadow[rs2], id_ex_o.store_data);
            check_val("addsub alu_fn", sub ? 32'(rv_pkg::ALU_SUB) : 32'(rv_pkg::ALU_ADD),
                      32'(id_ex_o.ctrl.alu_fn));
            check_val("addsub rd", 32'(rd), 32'(id_ex_o.ctrl.rd));
            check_val("addsub rs1", 32'(rs1), 32'(id_ex_o.ctrl.rs1));
            check_val("addsub rs2", 32'(rs2), 32'(id_ex_o.ctrl.rs2));
            check_val("addsub reg_we", 32'd1, 32'(id_ex_o.ctrl.reg_we));
            check_val("addsub b_is_imm", 32'd0, 32'(id_ex_o.ctrl.b_is_imm));
        end
    endtask

    task automatic test_write_through();
        rv_pkg::wb_port_t wb;
        // Write x7 and read it in the same cycle
        wb.we   = 1'b1;
        wb.rd   = 5'd7;
        wb.data = next_rand();
        issue(enc_addsub(1'b0, 5'd0, 5'd7, 5'd3), 32'h0, 1'b0, 1'b0, wb);
        shadow[7] = wb.data;
        check_val("bypass op_a", shadow[7], id_ex_o.op_a);
        check_val("bypass x0 op_b", 32'd0, id_ex_o.op_b);
        // A write to x0 is dropped even on the bypass path
        wb.rd   = 5'd0;
        wb.data = next_rand();
        issue(enc_addsub(1'b0, 5'd7, 5'd0, 5'd1), 32'h0, 1'b0, 1'b0, wb);
        check_val("x0 bypass op_a", 32'd0, id_ex_o.op_a);
        issue(enc_addsub(1'b0, 5'd7, 5'd0, 5'd1), 32'h0, 1'b0, 1'b0, NO_WB);
        check_val("x0 read op_a", 32'd0, id_ex_o.op_a);
        check_val("x7 kept op_b", shadow[7], id_ex_o.op_b);
    endtask

    task automatic test_immediates();
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::reg_addr_t rd;
        logic [31:0]       r;
        logic [11:0]       imm12;
        logic [12:0]       imm13;
        logic [20:0]       imm21;
        for (int k = 0; k < 2; k++) begin
            rs1   = rand_reg();
            rs2   = rand_reg();
            rd    = rand_reg();
            r     = next_rand();
            imm12 = r[11:0];
            imm13 = {r[12:1], 1'b0};
            imm21 = {r[20:1], 1'b0};
            // ADDI
            issue({imm12, rs1, 3'b000, rd, 7'b0010011}, 32'h0, 1'b0, 1'b0, NO_WB);
            check_val("addi op_b", {{20{imm12[11]}}, imm12}, id_ex_o.op_b);
            check_val("addi op_a", shadow[rs1], id_ex_o.op_a);
            check_val("addi mem_read", 32'd0, 32'(id_ex_o.ctrl.mem_read));
            // LW
            issue({imm12, rs1, 3'b010, rd, 7'b0000011}, 32'h0, 1'b0, 1'b0, NO_WB);
            check_val("lw op_b", {{20{imm12[11]}}, imm12}, id_ex_o.op_b);
            check_val("lw mem_read", 32'd1, 32'(id_ex_o.ctrl.mem_read));
            check_val("lw mem_to_reg", 32'd1, 32'(id_ex_o.ctrl.mem_to_reg));
            check_val("lw mem_type", 32'd2, 32'(id_ex_o.ctrl.mem_type));
            // SW
            issue({imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], 7'b0100011},
                  32'h0, 1'b0, 1'b0, NO_WB);
            check_val("sw op_b", {{20{imm12[11]}}, imm12}, id_ex_o.op_b);
            check_val("sw store_data", shadow[rs2], id_ex_o.store_data);
            check_val("sw mem_type", 32'd2, 32'(id_ex_o.ctrl.mem_type));
            check_val("sw reg_we", 32'd0, 32'(id_ex_o.ctrl.reg_we));
            // BEQ
            issue({imm13[12], imm13[10:5], rs2, rs1, 3'b000, imm13[4:1], imm13[11], 7'b1100011},
                  32'h0, 1'b0, 1'b0, NO_WB);
            check_val("beq op_b", {{19{imm13[12]}}, imm13}, id_ex_o.op_b);
            check_val("beq branch", 32'(rv_pkg::BR_EQ), 32'(id_ex_o.branch));
            check_val("beq store_data", shadow[rs2], id_ex_o.store_data);
            // LUI
            issue({r[31:12], rd, 7'b0110111}, 32'h0, 1'b0, 1'b0, NO_WB);
            check_val("lui op_b", {r[31:12], 12'h000}, id_ex_o.op_b);
            check_val("lui alu_fn", 32'(rv_pkg::ALU_PASS_B), 32'(id_ex_o.ctrl.alu_fn));
            check_val("lui op_a", 32'd0, id_ex_o.op_a);
            // JAL
            issue({imm21[20], imm21[10:1], imm21[11], imm21[19:12], rd, 7'b1101111},
                  32'h0, 1'b0, 1'b0, NO_WB);
            check_val("jal op_b", {{11{imm21[20]}}, imm21}, id_ex_o.op_b);
            check_val("jal branch", 32'(rv_pkg::BR_JUMP), 32'(id_ex_o.branch));
            check_val("jal reg_we", 32'd1, 32'(id_ex_o.ctrl.reg_we));
        end
    endtask

    task automatic test_bubble();
        rv_pkg::reg_addr_t rs1;
        rv_pkg::reg_addr_t rs2;
        rv_pkg::word_t     pc4;
        rs1 = rand_reg();
        rs2 = rand_reg();
        pc4 = next_rand() & 32'hffff_fffc;
        // BEQ under a bubble, so ctrl and branch would both be live without it
        issue({7'h00, rs2, rs1, 3'b000, 5'd0, 7'b1100011}, pc4, 1'b0, 1'b1, NO_WB);
        check_val("bubble ctrl", 32'd0, 32'(id_ex_o.ctrl));
        check_val("bubble branch", 32'(rv_pkg::BR_NONE), 32'(id_ex_o.branch));
        check_val("bubble op_a", shadow[rs1], id_ex_o.op_a);
        check_val("bubble pc_plus4", pc4, id_ex_o.pc_plus4);
        // ADD with bits 1:0 cleared is not a 32-bit encoding
        issue(enc_addsub(1'b0, 5'd2, 5'd1, 5'd4) & 32'hffff_fffc, 32'h0, 1'b0, 1'b0, NO_WB);
        check_val("invalid ctrl", 32'd0, 32'(id_ex_o.ctrl));
    endtask

    task automatic test_passthrough();
        rv_pkg::word_t pc4;
        logic [31:0]   r;
        for (int k = 0; k < 8; k++) begin
            r   = next_rand();
            pc4 = r & 32'hffff_fffc;
            issue({r[31:20], rand_reg(), 3'b000, rand_reg(), 7'b0010011}, pc4, r[7], 1'b0, NO_WB);
            check_val("pass pc_plus4", pc4, id_ex_o.pc_plus4);
            check_val("pass pred_taken", 32'(r[7]), 32'(id_ex_o.pred_taken));
        end
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst_n_i      = 1'b0;
        instr_i      = '0;
        pc_plus4_i   = '0;
        pred_taken_i = 1'b0;
        bubble_i     = 1'b0;
        wb_i         = NO_WB;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;
        test_reset();
        test_reg_rw();
        test_write_through();
        test_immediates();
        test_bubble();
        test_passthrough();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within their cycle budget");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+logic
logic/rv_pkg.sv
logic/rv32i_decoder.sv
logic/imm_gen.sv
logic/register_file.sv
logic/decode_stage.sv
logic/id_ex_register.sv
logic/id_top.sv
verif/id_top_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= id_top_tb
FLIST     ?= tb.f
BUILD     ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= Result: PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)
